// File: Bender.yml
package:
  name: fixed_lag_smoother

export_include_dirs:
  - source

sources:
  - files:
      - source/smoother_pkg.sv
      - source/smoother_if.sv
      - source/lag_sequencer.sv
      - source/rts_step.sv
      - source/model_mix.sv
      - source/fixed_lag_smoother.sv
  - target: simulation
    files:
      - testbench/smoother_checker.sv
      - testbench/tb_fixed_lag_smoother.sv

// File: filelist.f
+incdir+source
source/smoother_pkg.sv
source/smoother_if.sv
source/lag_sequencer.sv
source/rts_step.sv
source/model_mix.sv
source/fixed_lag_smoother.sv
testbench/smoother_checker.sv
testbench/tb_fixed_lag_smoother.sv

// File: source/fixed_lag_smoother.sv
// Fixed-lag IMM smoother top, joining the decode, execute and result stages
`timescale 1ns/1ps
`include "smoother_settings.svh"

module fixed_lag_smoother
    import smoother_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    // Forward pass from the IMM core
    input  logic fwd_valid,
    input  logic enable,
    input  fp_t  fwd_xf [`SMOOTH_N_MODELS][`SMOOTH_STATE_DIM],
    input  fp_t  fwd_xp [`SMOOTH_N_MODELS][`SMOOTH_STATE_DIM],
    input  fp_t  fwd_mu [`SMOOTH_N_MODELS],
    // Steady-state gain per model
    input  fp_t  gain   [`SMOOTH_N_MODELS][`SMOOTH_STATE_DIM][`SMOOTH_STATE_DIM],
    output logic busy,
    // Smoothed result for the oldest window sample
    output logic smooth_valid,
    output fp_t  x_smooth       [`SMOOTH_STATE_DIM],
    output fp_t  x_smooth_model [`SMOOTH_N_MODELS][`SMOOTH_STATE_DIM]
);

    // --------------------
    // Stage buses
    // --------------------
    step_if step_bus ();
    mix_if  mix_bus ();

    // Buffer and pass sequencing
    lag_sequencer u_lag_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .fwd_valid (fwd_valid),
        .enable    (enable),
        .fwd_xf    (fwd_xf),
        .fwd_xp    (fwd_xp),
        .fwd_mu    (fwd_mu),
        .busy      (busy),
        .step      (step_bus.seq),
        .mix       (mix_bus.seq)
    );

    // RTS update per model
    rts_step u_rts_step (
        .clk   (clk),
        .rst_n (rst_n),
        .gain  (gain),
        .step  (step_bus.exec),
        .mix   (mix_bus.xs_src)
    );

    // Weighted mix and outputs
    model_mix u_model_mix (
        .clk            (clk),
        .rst_n          (rst_n),
        .mix            (mix_bus.mix),
        .smooth_valid   (smooth_valid),
        .x_smooth       (x_smooth),
        .x_smooth_model (x_smooth_model)
    );

endmodule

// File: source/lag_sequencer.sv
// Decode stage of the smoother, holding the history buffer and sequencing the backward pass
`timescale 1ns/1ps
`include "smoother_settings.svh"

module lag_sequencer
    import smoother_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic fwd_valid,
    input  logic enable,
    input  fp_t  fwd_xf [`SMOOTH_N_MODELS][`SMOOTH_STATE_DIM],
    input  fp_t  fwd_xp [`SMOOTH_N_MODELS][`SMOOTH_STATE_DIM],
    input  fp_t  fwd_mu [`SMOOTH_N_MODELS],
    output logic busy,
    step_if.seq  step,
    mix_if.seq   mix
);

    localparam int N       = `SMOOTH_N_MODELS;
    localparam int D       = `SMOOTH_STATE_DIM;
    localparam int L       = `SMOOTH_LAG_DEPTH;
    localparam int PTR_W   = (L > 1) ? $clog2(L) : 1;
    localparam int FILL_W  = $clog2(L + 1);
    localparam int MODEL_W = `SMOOTH_MODEL_BITS;

    // --------------------
    // History buffer
    // --------------------
    fp_t buf_xf [L][N][D];
    fp_t buf_xp [L][N][D];
    fp_t buf_mu [L][N];

    logic [PTR_W-1:0]   wr_ptr;
    logic [FILL_W-1:0]  fill_count;
    logic               buffer_full;
    logic               accept;

    // Pass bookkeeping
    seq_state_t         state;
    logic [PTR_W-1:0]   k_idx;
    logic [PTR_W-1:0]   k_next;
    logic [PTR_W-1:0]   k_prev;
    logic [PTR_W-1:0]   newest;
    logic [MODEL_W-1:0] model_idx;
    logic               last_model;

    assign buffer_full = (fill_count == FILL_W'(L));
    // Full window or running pass blocks new samples
    assign busy        = (state != SEQ_IDLE) || buffer_full;
    assign accept      = fwd_valid && enable && !busy;

    // Circular neighbours
    assign newest = (wr_ptr == '0) ? PTR_W'(L - 1) : wr_ptr - 1'b1;
    assign k_prev = (k_idx == '0) ? PTR_W'(L - 1) : k_idx - 1'b1;
    assign k_next = (k_idx == PTR_W'(L - 1)) ? '0 : k_idx + 1'b1;

    assign last_model = (model_idx == MODEL_W'(N - 1));

    // Sample payload only
    always_ff @(posedge clk) begin
        if (accept) begin
            buf_xf[wr_ptr] <= fwd_xf;
            buf_xp[wr_ptr] <= fwd_xp;
            buf_mu[wr_ptr] <= fwd_mu;
        end
    end

    // Write pointer and fill level
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            fill_count <= '0;
        end else if (accept) begin
            wr_ptr     <= (wr_ptr == PTR_W'(L - 1)) ? '0 : wr_ptr + 1'b1;
            fill_count <= fill_count + 1'b1;
        end else if (state == SEQ_MIX) begin
            // Oldest slot retires, next accepted sample refills the window
            fill_count <= fill_count - 1'b1;
        end
    end

    // --------------------
    // Backward-pass FSM
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SEQ_IDLE;
            k_idx     <= '0;
            model_idx <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (buffer_full) begin
                        state     <= SEQ_INIT;
                        k_idx     <= newest;
                        model_idx <= '0;
                    end
                end
                // xs of every model seeded from newest xf
                SEQ_INIT: begin
                    if (step.done) begin
                        if (last_model) begin
                            model_idx <= '0;
                            k_idx     <= k_prev;
                            state     <= SEQ_ISSUE;
                        end else begin
                            model_idx <= model_idx + 1'b1;
                        end
                    end
                end
                SEQ_ISSUE: begin
                    state <= SEQ_WAIT;
                end
                SEQ_WAIT: begin
                    if (step.done) begin
                        if (!last_model) begin
                            model_idx <= model_idx + 1'b1;
                            state     <= SEQ_ISSUE;
                        end else if (k_idx == wr_ptr) begin
                            // Oldest timestep finished
                            model_idx <= '0;
                            state     <= SEQ_MIX;
                        end else begin
                            model_idx <= '0;
                            k_idx     <= k_prev;
                            state     <= SEQ_ISSUE;
                        end
                    end
                end
                SEQ_MIX: begin
                    state <= SEQ_IDLE;
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // Step operands, held until done since indices move only on done
    assign step.start   = (state == SEQ_INIT) || (state == SEQ_ISSUE);
    assign step.op      = (state == SEQ_INIT) ? STEP_INIT : STEP_SMOOTH;
    assign step.model   = model_idx;
    assign step.xf      = buf_xf[k_idx][model_idx];
    assign step.xp_next = buf_xp[k_next][model_idx];

    // Oldest sample sits at the write pointer when full
    assign mix.mix_go = (state == SEQ_MIX);
    assign mix.mu     = buf_mu[wr_ptr];

endmodule

// File: source/model_mix.sv
// Result stage of the smoother, mixing per-model states by mu and registering the outputs
`timescale 1ns/1ps
`include "smoother_settings.svh"

module model_mix
    import smoother_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    mix_if.mix   mix,
    output logic smooth_valid,
    output fp_t  x_smooth       [`SMOOTH_STATE_DIM],
    output fp_t  x_smooth_model [`SMOOTH_N_MODELS][`SMOOTH_STATE_DIM]
);

    localparam int N = `SMOOTH_N_MODELS;
    localparam int D = `SMOOTH_STATE_DIM;

    fp_t mix_sum [D];

    // Weighted sum per component, model 0 first, wrapping adds
    always_comb begin
        fp_t acc;
        for (int i = 0; i < D; i++) begin
            acc = '0;
            for (int m = 0; m < N; m++) begin
                acc = acc + fp_mul(mix.mu[m], mix.xs[m][i]);
            end
            mix_sum[i] = acc;
        end
    end

    // --------------------
    // Output registers
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            smooth_valid <= 1'b0;
            for (int i = 0; i < D; i++) begin
                x_smooth[i] <= '0;
                for (int m = 0; m < N; m++) begin
                    x_smooth_model[m][i] <= '0;
                end
            end
        end else begin
            // One-cycle pulse, results held until the next pass
            smooth_valid <= mix.mix_go;
            if (mix.mix_go) begin
                x_smooth       <= mix_sum;
                x_smooth_model <= mix.xs;
            end
        end
    end

endmodule

// File: source/rts_step.sv
// Execute stage of the smoother, running the per-model RTS update with one shared multiplier
`timescale 1ns/1ps
`include "smoother_settings.svh"

module rts_step
    import smoother_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  fp_t  gain [`SMOOTH_N_MODELS][`SMOOTH_STATE_DIM][`SMOOTH_STATE_DIM],
    step_if.exec step,
    mix_if.xs_src mix
);

    localparam int N     = `SMOOTH_N_MODELS;
    localparam int D     = `SMOOTH_STATE_DIM;
    localparam int IDX_W = (D > 1) ? $clog2(D) : 1;

    // Innovation, multiply-accumulate, write-back
    typedef enum logic [1:0] {
        PH_IDLE   = 2'd0,
        PH_MAC    = 2'd1,
        PH_UPDATE = 2'd2
    } phase_t;

    phase_t           phase;
    logic [IDX_W-1:0] row;
    logic [IDX_W-1:0] col;

    // Smoothed state per model
    fp_t xs    [N][D];
    fp_t innov [D];
    fp_t corr  [D];
    fp_t mac_prod;

    logic init_hit;
    logic smooth_hit;

    assign init_hit   = (phase == PH_IDLE) && step.start && (step.op == STEP_INIT);
    assign smooth_hit = (phase == PH_IDLE) && step.start && (step.op == STEP_SMOOTH);

    // Single multiplier, one gain entry per cycle
    assign mac_prod = fp_mul(gain[step.model][row][col], innov[col]);

    // Init finishes in its own cycle, smooth in the write-back cycle
    assign step.done = init_hit || (phase == PH_UPDATE);

    // --------------------
    // Control and xs
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= PH_IDLE;
            row   <= '0;
            col   <= '0;
            for (int m = 0; m < N; m++) begin
                for (int i = 0; i < D; i++) begin
                    xs[m][i] <= '0;
                end
            end
        end else begin
            case (phase)
                PH_IDLE: begin
                    if (init_hit) begin
                        xs[step.model] <= step.xf;
                    end else if (smooth_hit) begin
                        row   <= '0;
                        col   <= '0;
                        phase <= PH_MAC;
                    end
                end
                PH_MAC: begin
                    // Row-major walk, columns inner
                    if (col == IDX_W'(D - 1)) begin
                        col <= '0;
                        if (row == IDX_W'(D - 1)) begin
                            row   <= '0;
                            phase <= PH_UPDATE;
                        end else begin
                            row <= row + 1'b1;
                        end
                    end else begin
                        col <= col + 1'b1;
                    end
                end
                PH_UPDATE: begin
                    for (int i = 0; i < D; i++) begin
                        xs[step.model][i] <= step.xf[i] + corr[i];
                    end
                    phase <= PH_IDLE;
                end
                default: begin
                    phase <= PH_IDLE;
                end
            endcase
        end
    end

    // --------------------
    // Datapath registers
    // --------------------
    always_ff @(posedge clk) begin
        // xs[k+1] minus xp[k+1]
        if (smooth_hit) begin
            for (int i = 0; i < D; i++) begin
                innov[i] <= xs[step.model][i] - step.xp_next[i];
            end
        end
        // First column restarts the row sum
        if (phase == PH_MAC) begin
            corr[row] <= (col == '0) ? mac_prod : corr[row] + mac_prod;
        end
    end

    assign mix.xs = xs;

endmodule

// File: source/smoother_if.sv
// Smoother internal buses between decode, execute and result stages
`timescale 1ns/1ps
`include "smoother_settings.svh"

// --------------------
// Step bus
// --------------------

// One backward-pass step, sequencer to execute stage
interface step_if
    import smoother_pkg::*;
();
    logic                            start;
    step_op_t                        op;
    logic [`SMOOTH_MODEL_BITS-1:0]   model;
    fp_t                             xf      [`SMOOTH_STATE_DIM];
    fp_t                             xp_next [`SMOOTH_STATE_DIM];
    logic                            done;

    modport seq  (output start, op, model, xf, xp_next, input  done);
    modport exec (input  start, op, model, xf, xp_next, output done);
endinterface

// --------------------
// Mix bus
// --------------------

// Oldest-sample weights and smoothed states toward the result stage
interface mix_if
    import smoother_pkg::*;
();
    logic mix_go;
    fp_t  mu [`SMOOTH_N_MODELS];
    fp_t  xs [`SMOOTH_N_MODELS][`SMOOTH_STATE_DIM];

    modport seq    (output mix_go, mu);
    modport xs_src (output xs);
    modport mix    (input  mix_go, mu, xs);
endinterface

// File: source/smoother_pkg.sv
// Fixed-lag smoother shared types, step opcodes, sequencer states and Q16.16 multiply
`include "smoother_settings.svh"

package smoother_pkg;

    // Signed Q16.16 sample
    typedef logic signed [31:0] fp_t;

    // One execute-stage operation
    typedef enum logic [0:0] {
        STEP_INIT   = 1'b0,
        STEP_SMOOTH = 1'b1
    } step_op_t;

    // Backward-pass sequencer states
    typedef enum logic [2:0] {
        SEQ_IDLE  = 3'd0,
        SEQ_INIT  = 3'd1,
        SEQ_ISSUE = 3'd2,
        SEQ_WAIT  = 3'd3,
        SEQ_MIX   = 3'd4
    } seq_state_t;

    // Full 64-bit product, arithmetic shift by the fraction width, low 32 bits kept
    function automatic fp_t fp_mul(input fp_t a, input fp_t b);
        logic signed [63:0] prod;
        logic signed [63:0] shifted;
        prod    = a * b;
        shifted = prod >>> `SMOOTH_FRAC_BITS;
        return shifted[31:0];
    endfunction

endpackage

// File: source/smoother_settings.svh
// Fixed-lag smoother build constants for model bank, state vector, window and number format
`ifndef SMOOTHER_SETTINGS_SVH
`define SMOOTHER_SETTINGS_SVH

// --------------------
// Model bank and state
// --------------------

// Motion models run in parallel by the IMM core
`define SMOOTH_N_MODELS 2

// Length of each state vector
`define SMOOTH_STATE_DIM 2

// Buffered forward samples, i.e. the smoothing window
`define SMOOTH_LAG_DEPTH 4

// Q16.16 fraction width
`define SMOOTH_FRAC_BITS 16

// Model index width, kept at least one bit wide
`define SMOOTH_MODEL_BITS ((`SMOOTH_N_MODELS > 1) ? $clog2(`SMOOTH_N_MODELS) : 1)

`endif

// File: testbench/smoother_checker.sv
// Smoother output monitor, tracking the window fill and comparing results with the pattern file
`timescale 1ns/1ps
`include "smoother_settings.svh"

module smoother_checker
    import smoother_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic fwd_valid,
    input  logic enable,
    input  logic busy,
    input  logic smooth_valid,
    input  fp_t  x_smooth       [`SMOOTH_STATE_DIM],
    input  fp_t  x_smooth_model [`SMOOTH_N_MODELS][`SMOOTH_STATE_DIM],
    output int   error_count,
    output int   pass_count,
    output int   result_count
);

    localparam int    N            = `SMOOTH_N_MODELS;
    localparam int    D            = `SMOOTH_STATE_DIM;
    localparam int    L            = `SMOOTH_LAG_DEPTH;
    localparam int    VALS         = D + N * D;
    localparam string PATTERN_FILE = "testbench/smoother_patterns.txt";

    string exp_name [$];
    fp_t   exp_val  [$];
    int    fill;
    bit    in_reset;
    bit    reset_bad;

    // --------------------
    // Expected results
    // --------------------
    initial begin
        int    fd;
        int    code;
        string kind;
        string name;
        string rest;
        fp_t   v;
        error_count  = 0;
        pass_count   = 0;
        result_count = 0;
        fill         = 0;
        in_reset     = 1'b1;
        reset_bad    = 1'b0;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd != 0) begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind == "E") begin
                    code = $fscanf(fd, "%s", name);
                    exp_name.push_back(name);
                    for (int j = 0; j < VALS; j++) begin
                        code = $fscanf(fd, "%h", v);
                        exp_val.push_back(v);
                    end
                end
                code = $fgets(rest, fd);
            end
            $fclose(fd);
        end
    end

    function automatic bit outputs_clear();
        bit clear;
        clear = !busy && !smooth_valid;
        for (int i = 0; i < D; i++) begin
            clear &= (x_smooth[i] == '0);
            for (int m = 0; m < N; m++) begin
                clear &= (x_smooth_model[m][i] == '0);
            end
        end
        return clear;
    endfunction

    task automatic compare_result();
        string name;
        string field;
        fp_t   act;
        fp_t   exp;
        int    bad;
        bad = 0;
        if (exp_name.size() == 0) begin
            $display("Extra smooth_valid with no expected result left");
            error_count++;
        end else begin
            name = exp_name.pop_front();
            for (int j = 0; j < VALS; j++) begin
                exp = exp_val.pop_front();
                if (j < D) begin
                    act   = x_smooth[j];
                    field = $sformatf("x_smooth[%0d]", j);
                end else begin
                    act   = x_smooth_model[(j - D) / D][(j - D) % D];
                    field = $sformatf("x_smooth_model[%0d][%0d]", (j - D) / D, (j - D) % D);
                end
                if (act !== exp) begin
                    $display("Mismatch %s %s expected %h actual %h", name, field, exp, act);
                    bad++;
                end
            end
            result_count++;
            if (bad == 0) begin
                pass_count++;
                $display("Test %s passed", name);
            end else begin
                error_count++;
                $display("Test %s failed", name);
            end
        end
    endtask

    // Falling edge, inputs and outputs both settled
    always @(negedge clk) begin
        if (!rst_n) begin
            fill     = 0;
            in_reset = 1'b1;
            if (!outputs_clear()) begin
                $display("Outputs not cleared while reset is held");
                error_count++;
                reset_bad = 1'b1;
            end
        end else begin
            if (in_reset) begin
                in_reset = 1'b0;
                if (reset_bad) begin
                    $display("Test reset_release failed");
                end else begin
                    $display("Test reset_release passed");
                end
                reset_bad = 1'b0;
            end
            if (busy && fill < L) begin
                $display("Busy went high with only %0d samples in the window", fill);
                error_count++;
            end
            if (smooth_valid) begin
                if (fill < L) begin
                    $display("Result appeared with only %0d samples in the window", fill);
                    error_count++;
                end
                compare_result();
                fill--;
            end
            if (fwd_valid && enable && !busy) begin
                fill++;
            end
        end
    end

endmodule

// File: testbench/smoother_patterns.txt
# G: gain[m][r][c] | S/B: valid enable xf[m][i] xp[m][i] mu[m] tag (B lands during a pass)
# R: reset | E: tag x_smooth[i] x_smooth_model[m][i], in result order, all values Q16.16 hex
G 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
S 1 1 00010000 00020000 FFFF0000 00010000 00000000 00010000 FFFE0000 00000000 0000C000 00004000 s1
S 1 1 00020000 00020000 FFFE0000 00010000 00000000 00010000 FFFD0000 FFFF0000 00008000 00008000 s2
S 1 1 00030000 00020000 FFFD0000 00010000 00000000 00010000 FFFC0000 FFFE0000 0000C000 00004000 s3
S 1 1 00040000 00020000 FFFC0000 00010000 00000000 00010000 FFFB0000 FFFD0000 00008000 00008000 s4
S 1 1 00050000 00020000 FFFB0000 00010000 00000000 00010000 FFFA0000 FFFC0000 0000C000 00004000 s5
B 1 1 00640000 00640000 00640000 00640000 00640000 00640000 00640000 00640000 00010000 00000000 busy
S 1 0 00640000 00640000 00640000 00640000 00640000 00640000 00640000 00640000 00010000 00000000 off
G 00008000 00000000 00000000 00008000 00000000 00010000 00010000 00000000
S 1 1 00060000 00020000 FFFA0000 00010000 00000000 00010000 FFF90000 FFFB0000 00008000 00008000 s6
S 1 1 00070000 00020000 FFF90000 00010000 00000000 00010000 FFF80000 FFFA0000 0000C000 00004000 s7
R
S 1 1 00080000 00020000 FFF80000 00010000 00000000 00010000 FFF70000 FFF90000 00008000 00008000 s8
S 1 1 00090000 00020000 FFF70000 00010000 00000000 00010000 FFF60000 FFF80000 0000C000 00004000 s9
S 1 1 000A0000 00020000 FFF60000 00010000 00000000 00010000 FFF50000 FFF70000 00008000 00008000 s10
S 1 1 000B0000 00020000 FFF50000 00010000 00000000 00010000 FFF40000 FFF60000 0000C000 00004000 s11
# Expected results
E zero_gain_window 00008000 0001C000 00010000 00020000 FFFF0000 00010000
E back_to_back 00000000 00018000 00020000 00020000 FFFE0000 00010000
E skip_dropped 00074000 00042800 00070000 0002E000 00080000 00080000
E nonzero_gain 0008F000 0005F000 0008E000 0002E000 00090000 00090000
E after_reset 000EB000 0007F000 00106000 0002E000 000D0000 000D0000

// File: testbench/tb_fixed_lag_smoother.sv
// Fixed-lag smoother testbench top, driving pattern-file stimulus into the DUT with a cycle limit
`timescale 1ns/1ps
`include "smoother_settings.svh"

module tb_fixed_lag_smoother
    import smoother_pkg::*;
();

    localparam int    N              = `SMOOTH_N_MODELS;
    localparam int    D              = `SMOOTH_STATE_DIM;
    localparam int    CLK_PERIOD     = 8;
    localparam int    PASS_CYCLES    = 65;
    localparam int    TIMEOUT_MARGIN = 200;
    localparam string PATTERN_FILE   = "testbench/smoother_patterns.txt";

    logic clk;
    logic rst_n;
    logic fwd_valid;
    logic enable;
    fp_t  fwd_xf [N][D];
    fp_t  fwd_xp [N][D];
    fp_t  fwd_mu [N];
    fp_t  gain   [N][D][D];
    logic busy;
    logic smooth_valid;
    fp_t  x_smooth       [D];
    fp_t  x_smooth_model [N][D];

    int error_count;
    int pass_count;
    int result_count;
    int line_count;
    int exp_count;
    int cycle_count;
    int cycle_limit;
    int fd;
    integer seed;

    fixed_lag_smoother UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .fwd_valid      (fwd_valid),
        .enable         (enable),
        .fwd_xf         (fwd_xf),
        .fwd_xp         (fwd_xp),
        .fwd_mu         (fwd_mu),
        .gain           (gain),
        .busy           (busy),
        .smooth_valid   (smooth_valid),
        .x_smooth       (x_smooth),
        .x_smooth_model (x_smooth_model)
    );

    smoother_checker u_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .fwd_valid      (fwd_valid),
        .enable         (enable),
        .busy           (busy),
        .smooth_valid   (smooth_valid),
        .x_smooth       (x_smooth),
        .x_smooth_model (x_smooth_model),
        .error_count    (error_count),
        .pass_count     (pass_count),
        .result_count   (result_count)
    );

    // --------------------
    // Clock and run limit
    // --------------------
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles with %0d of %0d results seen",
                     cycle_count, result_count, exp_count);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // Lines and expected results, sizing the cycle limit
    task automatic count_pattern_lines(output bit ok);
        string line;
        string kind;
        int    code;
        line_count = 0;
        exp_count  = 0;
        fd = $fopen(PATTERN_FILE, "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fgets(line, fd) != 0) begin
                line_count++;
                code = $sscanf(line, "%s", kind);
                if (code == 1 && kind == "E") begin
                    exp_count++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Sampled on the falling edge where busy is settled
    task automatic wait_idle();
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic wait_busy();
        @(negedge clk);
        while (!busy) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic apply_gain();
        fp_t g [N*D*D];
        int  code;
        for (int j = 0; j < N * D * D; j++) begin
            code = $fscanf(fd, "%h", g[j]);
        end
        wait_idle();
        for (int m = 0; m < N; m++) begin
            for (int r = 0; r < D; r++) begin
                for (int c = 0; c < D; c++) begin
                    gain[m][r][c] <= g[(m * D + r) * D + c];
                end
            end
        end
    endtask

    // One-cycle offer, S waits for idle after a random gap, B lands during a pass
    task automatic drive_sample(input bit during_pass);
        fp_t v [2*N*D+N];
        int  valid_v;
        int  en_v;
        int  gap;
        int  code;
        code = $fscanf(fd, "%d %d", valid_v, en_v);
        for (int j = 0; j < 2 * N * D + N; j++) begin
            code = $fscanf(fd, "%h", v[j]);
        end
        if (during_pass) begin
            wait_busy();
        end else begin
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(posedge clk);
            wait_idle();
        end
        fwd_valid <= valid_v[0];
        enable    <= en_v[0];
        for (int m = 0; m < N; m++) begin
            fwd_mu[m] <= v[2 * N * D + m];
            for (int i = 0; i < D; i++) begin
                fwd_xf[m][i] <= v[m * D + i];
                fwd_xp[m][i] <= v[N * D + m * D + i];
            end
        end
        @(posedge clk);
        fwd_valid <= 1'b0;
        enable    <= 1'b0;
    endtask

    task automatic pulse_reset();
        wait_idle();
        rst_n <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic run_patterns();
        string kind;
        string rest;
        int    code;
        fd = $fopen(PATTERN_FILE, "r");
        while ($fscanf(fd, "%s", kind) == 1) begin
            case (kind)
                "G":     apply_gain();
                "S":     drive_sample(1'b0);
                "B":     drive_sample(1'b1);
                "R":     pulse_reset();
                default: ;
            endcase
            code = $fgets(rest, fd);
        end
        $fclose(fd);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        bit ok;
        seed        = 32'h8fa74208;
        cycle_count = 0;
        cycle_limit = 0;
        rst_n       = 1'b0;
        fwd_valid   = 1'b0;
        enable      = 1'b0;
        for (int m = 0; m < N; m++) begin
            fwd_mu[m] = '0;
            for (int i = 0; i < D; i++) begin
                fwd_xf[m][i] = '0;
                fwd_xp[m][i] = '0;
                for (int c = 0; c < D; c++) begin
                    gain[m][i][c] = '0;
                end
            end
        end
        count_pattern_lines(ok);
        if (!ok) begin
            $display("Pattern file %s could not be opened", PATTERN_FILE);
            $display("TESTS FAILED");
            $finish;
        end else begin
            cycle_limit = line_count * 4 + exp_count * PASS_CYCLES + TIMEOUT_MARGIN;
            repeat (5) @(posedge clk);
            rst_n <= 1'b1;
            run_patterns();
            while (result_count < exp_count) begin
                @(posedge clk);
            end
            // Room for a stray extra pulse
            repeat (10) @(posedge clk);
            $display("Results %0d of %0d, passed %0d, errors %0d",
                     result_count, exp_count, pass_count, error_count);
            if (error_count == 0 && result_count == exp_count) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

endmodule
